// ==== flist.f ====
+incdir+verification
logic/core_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_top.sv
verification/pipeline_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module pipeline_tb -Mdir obj_dir -f flist.f
	./obj_dir/Vpipeline_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/isa_model.svh ====
`ifndef isa_model_svh
`define isa_model_svh

// Expected commit streams, both in program order
core_pkg::reg_addr_t expect_reg_addr [$];
logic [data_width-1:0] expect_reg_data [$];
logic [data_width-1:0] expect_store_addr [$];
logic [data_width-1:0] expect_store_data [$];

////////////////////////////////////////////////////////////////////////////
// Instruction-at-a-time reference

// Runs the program from PC 0 until write_target register writes are queued
task automatic run_model(input int write_target, input int step_limit);
	logic [data_width-1:0] regs [32];
	logic [data_width-1:0] data_mem [2**data_width];
	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] next_pc;
	core_pkg::instr_u word;
	logic [data_width-1:0] a;
	logic [data_width-1:0] b;
	logic [data_width-1:0] result;
	int steps;

	// Same start state as the core after reset
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < 2**data_width; i++) begin
		data_mem[i] = '0;
	end
	pc = '0;
	steps = 0;

	while (expect_reg_addr.size() < write_target) begin
		if (steps >= step_limit) begin
			abort_run($sformatf("The model ran %0d steps without reaching %0d register writes",
				steps, write_target));
		end
		word = program_mem[pc];
		a = regs[word.r.rs1];
		b = regs[word.r.rs2];
		result = '0;
		next_pc = pc + pc_width'(1);
		case (word.r.opcode)
			core_pkg::op_add: result = a + b;
			core_pkg::op_sub: result = a - b;
			core_pkg::op_and: result = a & b;
			core_pkg::op_or: result = a | b;
			core_pkg::op_xor: result = a ^ b;
			core_pkg::op_load: result = data_mem[a];
			core_pkg::op_store: begin
				data_mem[a] = b;
				expect_store_addr.push_back(a);
				expect_store_data.push_back(b);
			end
			// Target is the branch's own PC minus the zero-extended offset
			core_pkg::op_beq: begin
				if (a == b) begin
					next_pc = pc - pc_width'(word.b.offset);
				end
			end
			core_pkg::op_bne: begin
				if (a != b) begin
					next_pc = pc - pc_width'(word.b.offset);
				end
			end
			default: result = '0;
		endcase
		if (word.r.opcode inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
			core_pkg::op_or, core_pkg::op_xor, core_pkg::op_load}) begin
			regs[word.r.rd] = result;
			expect_reg_addr.push_back(word.r.rd);
			expect_reg_data.push_back(result);
		end
		pc = next_pc;
		steps++;
	end
endtask

`endif

// ==== verification/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb;

	localparam int data_width = 8;
	localparam int pc_width = 8;
	localparam int program_words = 256;
	localparam int write_target = 300;
	localparam int cycles_per_write = 20;
	localparam int reset_cycles = 5;
	localparam int clk_period = 10;
	localparam int drive_delay = 1;
	localparam int watchdog_cycles = write_target * cycles_per_write + reset_cycles;

	logic clk;
	logic reset;
	logic [pc_width-1:0] imem_addr;
	logic [core_pkg::instr_width-1:0] imem_data;
	logic reg_write_en;
	core_pkg::reg_addr_t reg_write_addr;
	logic [data_width-1:0] reg_write_data;
	logic mem_write_en;
	logic [data_width-1:0] mem_write_addr;
	logic [data_width-1:0] mem_write_data;

	core_pkg::instr_u program_mem [program_words];
	integer seed;
	int reg_commits;

	// Prints the reason and ends the run at the first error
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	`include "isa_model.svh"

	pipeline_top dut_i (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.reg_write_en(reg_write_en),
		.reg_write_addr(reg_write_addr),
		.reg_write_data(reg_write_data),
		.mem_write_en(mem_write_en),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data)
	);

	// Instruction memory answers in the same cycle
	assign imem_data = program_mem[imem_addr];

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Random program

	function automatic int random_below(input int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	task automatic build_program();
		core_pkg::instr_u word;
		core_pkg::opcode_e prev_op;
		int pick;

		prev_op = core_pkg::op_nop;
		for (int i = 0; i < program_words; i++) begin
			pick = random_below(10);
			// Branch only right behind a register writer, so each loop body writes
			if (pick >= 8 && !(prev_op inside {core_pkg::op_add, core_pkg::op_sub,
				core_pkg::op_and, core_pkg::op_or, core_pkg::op_xor, core_pkg::op_load})) begin
				pick = random_below(8);
			end
			word = '0;
			word.r.opcode = core_pkg::opcode_e'(5'(pick));
			// Eight registers keep producers and consumers close together
			word.r.rd = core_pkg::reg_addr_t'(random_below(8));
			word.r.rs2 = core_pkg::reg_addr_t'(random_below(8));
			word.r.rs1 = core_pkg::reg_addr_t'(random_below(8));
			if (word.r.opcode inside {core_pkg::op_beq, core_pkg::op_bne}) begin
				word.b.offset = 5'(1 + random_below(6));
			end
			program_mem[i] = word;
			prev_op = word.r.opcode;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_enable_low(input logic value, input string name);
		if (value !== 1'b0) begin
			abort_run($sformatf("FAILED at %0t: %s expected 0 got %b", $time, name, value));
		end
	endtask

	task automatic check_fetch_addr(input logic [pc_width-1:0] got,
		input logic [pc_width-1:0] want);
		if (got !== want) begin
			abort_run($sformatf("FAILED at %0t: imem_addr expected %0h got %0h",
				$time, want, got));
		end
	endtask

	task automatic check_reg_write(input core_pkg::reg_addr_t addr,
		input logic [data_width-1:0] data);
		core_pkg::reg_addr_t want_addr;
		logic [data_width-1:0] want_data;

		if (expect_reg_addr.size() == 0) begin
			abort_run("A register write committed after the expected writes ran out");
		end
		want_addr = expect_reg_addr.pop_front();
		want_data = expect_reg_data.pop_front();
		if (addr !== want_addr) begin
			abort_run($sformatf("FAILED at %0t: reg_write_addr expected %0d got %0d",
				$time, want_addr, addr));
		end
		if (data !== want_data) begin
			abort_run($sformatf("FAILED at %0t: reg_write_data expected %0h got %0h",
				$time, want_data, data));
		end
	endtask

	task automatic check_store(input logic [data_width-1:0] addr,
		input logic [data_width-1:0] data);
		logic [data_width-1:0] want_addr;
		logic [data_width-1:0] want_data;

		if (expect_store_addr.size() == 0) begin
			abort_run("A store committed that the program never reaches in order");
		end
		want_addr = expect_store_addr.pop_front();
		want_data = expect_store_data.pop_front();
		if (addr !== want_addr) begin
			abort_run($sformatf("FAILED at %0t: mem_write_addr expected %0h got %0h",
				$time, want_addr, addr));
		end
		if (data !== want_data) begin
			abort_run($sformatf("FAILED at %0t: mem_write_data expected %0h got %0h",
				$time, want_data, data));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and commit monitor

	initial begin
		seed = 32'he442_1b83;
		reset = 1'b1;
		reg_commits = 0;
		build_program();
		run_model(write_target, 100000);

		// Commit ports stay quiet through reset
		for (int c = 0; c < reset_cycles; c++) begin
			@(posedge clk);
			if (c == reset_cycles - 1) begin
				#drive_delay;
				reset = 1'b0;
			end
			@(negedge clk);
			check_enable_low(reg_write_en, "reg_write_en");
			check_enable_low(mem_write_en, "mem_write_en");
		end
		check_fetch_addr(imem_addr, '0);

		// Outputs are sampled mid-cycle, one commit per stream per cycle
		while (reg_commits < write_target) begin
			@(negedge clk);
			if (reg_write_en) begin
				check_reg_write(reg_write_addr, reg_write_data);
				reg_commits++;
			end
			// A store beside the last write is younger than it
			if (mem_write_en && reg_commits < write_target) begin
				check_store(mem_write_addr, mem_write_data);
			end
		end

		if (expect_store_addr.size() != 0) begin
			abort_run($sformatf("%0d stores before the last register write never committed",
				expect_store_addr.size()));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	initial begin
		#(watchdog_cycles * clk_period);
		abort_run($sformatf("Timeout after %0d cycles, the commits stopped", watchdog_cycles));
	end

endmodule

`default_nettype wire

// ==== logic/pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_top #(
	parameter int data_width = 8,
	parameter int pc_width = 8
) (
	input logic clk,
	input logic reset,
	output logic [pc_width-1:0] imem_addr,
	input logic [core_pkg::instr_width-1:0] imem_data,
	// Commit ports
	output logic reg_write_en,
	output core_pkg::reg_addr_t reg_write_addr,
	output logic [data_width-1:0] reg_write_data,
	output logic mem_write_en,
	output logic [data_width-1:0] mem_write_addr,
	output logic [data_width-1:0] mem_write_data
);

	// Fetch and decode
	core_pkg::instr_u decode_instr;
	logic [pc_width-1:0] decode_pc;
	logic stall;
	logic redirect;
	logic [pc_width-1:0] redirect_pc;

	// Decode/execute
	core_pkg::opcode_e ex_op;
	core_pkg::reg_addr_t ex_rs1;
	core_pkg::reg_addr_t ex_rs2;
	core_pkg::reg_addr_t ex_rd_q;
	logic [data_width-1:0] ex_val_a;
	logic [data_width-1:0] ex_val_b;
	logic ex_reg_write_q;
	logic ex_mem_write;
	logic ex_load_q;
	core_pkg::wb_sel_e ex_wb_sel;
	core_pkg::reg_addr_t ex_rd;
	logic ex_reg_write;
	logic ex_load;

	// Execute/memory
	core_pkg::reg_addr_t mem_rd;
	logic mem_reg_write;
	logic mem_mem_write;
	core_pkg::wb_sel_e mem_wb_sel;
	logic [data_width-1:0] mem_result;
	logic [data_width-1:0] mem_store_data;

	////////////////////////////////////////////////////////////////////////////
	// Stages

	fetch_stage #(
		.pc_width(pc_width)
	) fetch_stage_i (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.imem_data(imem_data),
		.imem_addr(imem_addr),
		.decode_instr(decode_instr),
		.decode_pc(decode_pc)
	);

	decode_stage #(
		.data_width(data_width),
		.pc_width(pc_width)
	) decode_stage_i (
		.clk(clk),
		.reset(reset),
		.decode_instr(decode_instr),
		.decode_pc(decode_pc),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_load(ex_load),
		.mem_rd(mem_rd),
		.mem_reg_write(mem_reg_write),
		.wb_reg_write(reg_write_en),
		.wb_rd(reg_write_addr),
		.wb_data(reg_write_data),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_op(ex_op),
		.ex_rs1(ex_rs1),
		.ex_rs2(ex_rs2),
		.ex_rd_out(ex_rd_q),
		.ex_val_a(ex_val_a),
		.ex_val_b(ex_val_b),
		.ex_reg_write_out(ex_reg_write_q),
		.ex_mem_write(ex_mem_write),
		.ex_load_out(ex_load_q),
		.ex_wb_sel(ex_wb_sel)
	);

	execute_stage #(
		.data_width(data_width)
	) execute_stage_i (
		.clk(clk),
		.reset(reset),
		.op(ex_op),
		.rs1(ex_rs1),
		.rs2(ex_rs2),
		.rd(ex_rd_q),
		.val_a(ex_val_a),
		.val_b(ex_val_b),
		.reg_write(ex_reg_write_q),
		.mem_write(ex_mem_write),
		.load(ex_load_q),
		.wb_sel(ex_wb_sel),
		.wb_rd(reg_write_addr),
		.wb_reg_write(reg_write_en),
		.wb_data(reg_write_data),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_load(ex_load),
		.mem_rd(mem_rd),
		.mem_reg_write(mem_reg_write),
		.mem_mem_write(mem_mem_write),
		.mem_wb_sel(mem_wb_sel),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data)
	);

	// Writeback outputs double as the register commit port
	memory_stage #(
		.data_width(data_width)
	) mem_stage_i (
		.clk(clk),
		.reset(reset),
		.mem_rd(mem_rd),
		.mem_reg_write(mem_reg_write),
		.mem_mem_write(mem_mem_write),
		.mem_wb_sel(mem_wb_sel),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.wb_rd(reg_write_addr),
		.wb_reg_write(reg_write_en),
		.wb_data(reg_write_data),
		.mem_write_en(mem_write_en),
		.mem_write_addr(mem_write_addr),
		.mem_write_data(mem_write_data)
	);

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
	parameter int data_width = 8
) (
	input logic clk,
	input logic reset,
	input core_pkg::reg_addr_t mem_rd,
	input logic mem_reg_write,
	input logic mem_mem_write,
	input core_pkg::wb_sel_e mem_wb_sel,
	input logic [data_width-1:0] mem_result,
	input logic [data_width-1:0] mem_store_data,
	output core_pkg::reg_addr_t wb_rd,
	output logic wb_reg_write,
	output logic [data_width-1:0] wb_data,
	output logic mem_write_en,
	output logic [data_width-1:0] mem_write_addr,
	output logic [data_width-1:0] mem_write_data
);

	// Byte memory addressed by a full register value
	logic [data_width-1:0] data_mem [2**data_width];
	logic [data_width-1:0] load_data;
	logic [data_width-1:0] wb_alu_q;
	logic [data_width-1:0] wb_load_q;
	core_pkg::wb_sel_e wb_sel_q;

	assign load_data = data_mem[mem_result];

	assign mem_write_en = mem_mem_write;
	assign mem_write_addr = mem_result;
	assign mem_write_data = mem_store_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**data_width; i++) begin
				data_mem[i] <= '0;
			end
		end else if (mem_mem_write) begin
			data_mem[mem_result] <= mem_store_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory/writeback register

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_reg_write <= 1'b0;
		end else begin
			wb_reg_write <= mem_reg_write;
		end
		wb_rd <= mem_rd;
		wb_sel_q <= mem_wb_sel;
		wb_alu_q <= mem_result;
		wb_load_q <= load_data;
	end

	assign wb_data = (wb_sel_q == core_pkg::wb_load) ? wb_load_q : wb_alu_q;

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
	parameter int data_width = 8
) (
	input logic clk,
	input logic reset,
	// Decode/execute fields
	input core_pkg::opcode_e op,
	input core_pkg::reg_addr_t rs1,
	input core_pkg::reg_addr_t rs2,
	input core_pkg::reg_addr_t rd,
	input logic [data_width-1:0] val_a,
	input logic [data_width-1:0] val_b,
	input logic reg_write,
	input logic mem_write,
	input logic load,
	input core_pkg::wb_sel_e wb_sel,
	// Writeback forwarding source
	input core_pkg::reg_addr_t wb_rd,
	input logic wb_reg_write,
	input logic [data_width-1:0] wb_data,
	// Hazard view for decode
	output core_pkg::reg_addr_t ex_rd,
	output logic ex_reg_write,
	output logic ex_load,
	// Execute/memory register
	output core_pkg::reg_addr_t mem_rd,
	output logic mem_reg_write,
	output logic mem_mem_write,
	output core_pkg::wb_sel_e mem_wb_sel,
	output logic [data_width-1:0] mem_result,
	output logic [data_width-1:0] mem_store_data
);

	core_pkg::fwd_sel_e fwd_a;
	core_pkg::fwd_sel_e fwd_b;
	logic [data_width-1:0] src_a;
	logic [data_width-1:0] src_b;
	logic [data_width-1:0] alu_result;
	logic use_a;
	logic use_b;

	assign ex_rd = rd;
	assign ex_reg_write = reg_write;
	assign ex_load = load;

	////////////////////////////////////////////////////////////////////////////
	// Forwarding unit

	// Newest producer wins and the memory stage is checked first
	function automatic core_pkg::fwd_sel_e pick_source(input core_pkg::reg_addr_t src);
		if (mem_reg_write && mem_rd == src) begin
			return core_pkg::fwd_mem;
		end
		if (wb_reg_write && wb_rd == src) begin
			return core_pkg::fwd_wb;
		end
		return core_pkg::fwd_reg;
	endfunction

	function automatic logic [data_width-1:0] operand(input core_pkg::fwd_sel_e sel,
		input logic [data_width-1:0] reg_val);
		case (sel)
			core_pkg::fwd_mem: return mem_result;
			core_pkg::fwd_wb: return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		fwd_a = pick_source(rs1);
		fwd_b = pick_source(rs2);
		src_a = operand(fwd_a, val_a);
		src_b = operand(fwd_b, val_b);
	end

	// Operands that the instruction in execute really consumes
	assign use_a = reg_write || mem_write;
	assign use_b = (reg_write && !load) || mem_write;

	////////////////////////////////////////////////////////////////////////////
	// ALU

	// Load and store pass rs1 through as the address
	always_comb begin
		case (op)
			core_pkg::op_add: alu_result = src_a + src_b;
			core_pkg::op_sub: alu_result = src_a - src_b;
			core_pkg::op_and: alu_result = src_a & src_b;
			core_pkg::op_or: alu_result = src_a | src_b;
			core_pkg::op_xor: alu_result = src_a ^ src_b;
			default: alu_result = src_a;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute/memory register

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_reg_write <= 1'b0;
			mem_mem_write <= 1'b0;
		end else begin
			mem_reg_write <= reg_write;
			mem_mem_write <= mem_write;
		end
		mem_rd <= rd;
		mem_wb_sel <= wb_sel;
		mem_result <= alu_result;
		mem_store_data <= src_b;
	end

	// A load in the memory stage still holds its address, not its data
	forward_no_load_address: assert property (
		@(posedge clk) disable iff (reset)
		((use_a && fwd_a == core_pkg::fwd_mem) || (use_b && fwd_b == core_pkg::fwd_mem))
		|-> mem_wb_sel == core_pkg::wb_alu
	);

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
	parameter int data_width = 8,
	parameter int pc_width = 8
) (
	input logic clk,
	input logic reset,
	input core_pkg::instr_u decode_instr,
	input logic [pc_width-1:0] decode_pc,
	// Hazard sources
	input core_pkg::reg_addr_t ex_rd,
	input logic ex_reg_write,
	input logic ex_load,
	input core_pkg::reg_addr_t mem_rd,
	input logic mem_reg_write,
	// Writeback
	input logic wb_reg_write,
	input core_pkg::reg_addr_t wb_rd,
	input logic [data_width-1:0] wb_data,
	// To fetch
	output logic stall,
	output logic redirect,
	output logic [pc_width-1:0] redirect_pc,
	// Decode/execute register
	output core_pkg::opcode_e ex_op,
	output core_pkg::reg_addr_t ex_rs1,
	output core_pkg::reg_addr_t ex_rs2,
	output core_pkg::reg_addr_t ex_rd_out,
	output logic [data_width-1:0] ex_val_a,
	output logic [data_width-1:0] ex_val_b,
	output logic ex_reg_write_out,
	output logic ex_mem_write,
	output logic ex_load_out,
	output core_pkg::wb_sel_e ex_wb_sel
);

	core_pkg::opcode_e op;
	core_pkg::reg_addr_t rs1;
	core_pkg::reg_addr_t rs2;
	logic [data_width-1:0] read_a;
	logic [data_width-1:0] read_b;
	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic uses_rs1;
	logic uses_rs2;
	logic load_use;
	logic branch_wait;
	logic taken;

	assign op = decode_instr.r.opcode;
	assign rs1 = decode_instr.r.rs1;
	assign rs2 = decode_instr.r.rs2;

	register_file #(
		.data_width(data_width)
	) register_file_i (
		.clk(clk),
		.reset(reset),
		.read_addr_a(rs1),
		.read_addr_b(rs2),
		.write_en(wb_reg_write),
		.write_addr(wb_rd),
		.write_data(wb_data),
		.read_data_a(read_a),
		.read_data_b(read_b)
	);

	////////////////////////////////////////////////////////////////////////////
	// Control decode

	assign is_alu = op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
		core_pkg::op_or, core_pkg::op_xor};
	assign is_load = op == core_pkg::op_load;
	assign is_store = op == core_pkg::op_store;
	assign is_branch = op inside {core_pkg::op_beq, core_pkg::op_bne};

	assign uses_rs1 = is_alu || is_load || is_store || is_branch;
	assign uses_rs2 = is_alu || is_store || is_branch;

	////////////////////////////////////////////////////////////////////////////
	// Hazards and branch resolution

	// Load data is not ready until writeback
	assign load_use = ex_load
		&& ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

	// Branches compare here, so wait for producers to reach writeback
	assign branch_wait = is_branch
		&& ((ex_reg_write && (ex_rd == rs1 || ex_rd == rs2))
		|| (mem_reg_write && (mem_rd == rs1 || mem_rd == rs2)));

	assign stall = load_use || branch_wait;

	assign taken = (op == core_pkg::op_beq && read_a == read_b)
		|| (op == core_pkg::op_bne && read_a != read_b);
	assign redirect = taken && !stall;
	assign redirect_pc = decode_pc - pc_width'(decode_instr.b.offset);

	////////////////////////////////////////////////////////////////////////////
	// Decode/execute register

	always_ff @(posedge clk) begin
		// Stall sends a bubble down
		if (reset || stall) begin
			ex_op <= core_pkg::op_nop;
			ex_reg_write_out <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_load_out <= 1'b0;
		end else begin
			ex_op <= op;
			ex_reg_write_out <= is_alu || is_load;
			ex_mem_write <= is_store;
			ex_load_out <= is_load;
		end
		ex_rs1 <= rs1;
		ex_rs2 <= rs2;
		ex_rd_out <= decode_instr.r.rd;
		ex_val_a <= read_a;
		ex_val_b <= read_b;
		ex_wb_sel <= is_load ? core_pkg::wb_load : core_pkg::wb_alu;
	end

	// A taken branch comes from a branch word and fetch squashes its successor
	redirect_from_branch: assert property (
		@(posedge clk) disable iff (reset)
		redirect |-> is_branch ##1 (decode_instr.r.opcode == core_pkg::op_nop)
	);

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file #(
	parameter int data_width = 8
) (
	input logic clk,
	input logic reset,
	input core_pkg::reg_addr_t read_addr_a,
	input core_pkg::reg_addr_t read_addr_b,
	input logic write_en,
	input core_pkg::reg_addr_t write_addr,
	input logic [data_width-1:0] write_data,
	output logic [data_width-1:0] read_data_a,
	output logic [data_width-1:0] read_data_b
);

	logic [data_width-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// Write-through, so decode sees the value retiring this cycle
	assign read_data_a = (write_en && write_addr == read_addr_a) ? write_data
		: regs[read_addr_a];
	assign read_data_b = (write_en && write_addr == read_addr_b) ? write_data
		: regs[read_addr_b];

endmodule

`default_nettype wire

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter int pc_width = 8
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic [pc_width-1:0] redirect_pc,
	input logic [core_pkg::instr_width-1:0] imem_data,
	output logic [pc_width-1:0] imem_addr,
	output core_pkg::instr_u decode_instr,
	output logic [pc_width-1:0] decode_pc
);

	logic [pc_width-1:0] pc;

	// Instruction memory is outside, read in the same cycle
	assign imem_addr = pc;

	////////////////////////////////////////////////////////////////////////////
	// Program counter

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall) begin
			pc <= pc + pc_width'(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Fetch/decode register

	// A taken branch squashes the word fetched behind it
	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			decode_instr <= '0;
		end else if (!stall) begin
			decode_instr <= imem_data;
			decode_pc <= pc;
		end
	end

	// Decode only redirects once its branch is free to resolve
	stall_redirect_exclusive: assert property (
		@(posedge clk) disable iff (reset) !(stall && redirect)
	);

endmodule

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word layout

	localparam int instr_width = 20;
	localparam int opcode_width = 5;
	localparam int reg_addr_width = 5;
	localparam int offset_width = 5;

	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// Codes 10 and above are undefined and behave as nop
	typedef enum logic [opcode_width-1:0] {
		op_nop = 5'd0,
		op_add = 5'd1,
		op_sub = 5'd2,
		op_and = 5'd3,
		op_or = 5'd4,
		op_xor = 5'd5,
		op_load = 5'd6,
		op_store = 5'd7,
		op_beq = 5'd8,
		op_bne = 5'd9
	} opcode_e;

	// Register form, bits 14..10 name the destination
	typedef struct packed {
		opcode_e opcode;
		reg_addr_t rd;
		reg_addr_t rs2;
		reg_addr_t rs1;
	} reg_form_t;

	// Branch form, bits 14..10 hold a backward offset
	typedef struct packed {
		opcode_e opcode;
		logic [offset_width-1:0] offset;
		reg_addr_t rs2;
		reg_addr_t rs1;
	} branch_form_t;

	typedef union packed {
		reg_form_t r;
		branch_form_t b;
	} instr_u;

	////////////////////////////////////////////////////////////////////////////
	// Data path selects

	typedef enum logic {
		wb_alu = 1'b0,
		wb_load = 1'b1
	} wb_sel_e;

	typedef enum logic [1:0] {
		fwd_reg = 2'd0,
		fwd_mem = 2'd1,
		fwd_wb = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire
